// File: Makefile
# gpio_lite simulation with Verilator
# usage: make lint | make sim | make clean

VERILATOR ?= verilator
TOP       ?= gpio_lite_tb
FILELIST  ?= gpio_lite.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  := *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides the result, not the exit code of the model
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -F -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: gpio_lite.f
+incdir+hdl
hdl/gpio_lite_pkg.sv
hdl/gpio_lite_in_sync.sv
hdl/gpio_lite_regs.sv
hdl/gpio_lite.sv
verif/gpio_lite_checker.sv
verif/gpio_lite_tb.sv

// File: hdl/gpio_lite.sv
/* gpio_lite top level
   wires the pin synchronizer to the register block */

`timescale 1ns/10ps

module gpio_lite
  import gpio_lite_pkg::*;
(
  input  logic       pclk13,            // apb clock
  input  logic       n_reset13,         // async reset, active low
  // apb slave
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  gpio_addr_t paddr,
  input  gpio_word_t pwdata,
  output gpio_word_t prdata,
  // pins
  input  gpio_word_t pin_in,            // from pads
  input  gpio_word_t tri_state_enable,  // test, all pins to Z
  output gpio_word_t pin_out,           // to pads
  output gpio_word_t pin_oe_n,          // pad enable, low active
  output logic       irq                // pin change interrupt
);

  // --------------------
  // input path to registers
  gpio_word_t pin_val;                  // synchronized pins
  gpio_word_t pin_rise;                 // edge flags

  gpio_lite_in_sync u_in_sync (
    .pclk13    (pclk13),
    .n_reset13 (n_reset13),
    .pin_in    (pin_in),
    .pin_val   (pin_val),
    .pin_rise  (pin_rise)
  );

  // --------------------
  // register block
  gpio_lite_regs u_regs (
    .pclk13           (pclk13),
    .n_reset13        (n_reset13),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .pin_val          (pin_val),
    .pin_rise         (pin_rise),
    .tri_state_enable (tri_state_enable),
    .prdata           (prdata),
    .pin_out          (pin_out),
    .pin_oe_n         (pin_oe_n),
    .irq              (irq)
  );

endmodule : gpio_lite

// File: hdl/gpio_lite_cfg.svh
/* gpio_lite configuration macros
   pin count, address width, register map, reset values */

`ifndef GPIO_LITE_CFG_SVH
`define GPIO_LITE_CFG_SVH

// --------------------
// sizes
`define GPIO_LITE_WIDTH    16             // pins, one register bit each
`define GPIO_LITE_ADDR_W   6              // apb register address bits

// --------------------
// register offsets
`define GPIO_LITE_REG_DIR  6'h04          // direction, 1 = input
`define GPIO_LITE_REG_OE   6'h08          // output enable
`define GPIO_LITE_REG_OUT  6'h0C          // output value
`define GPIO_LITE_REG_IN   6'h10          // synchronized input, read only
`define GPIO_LITE_REG_INT  6'h20          // interrupt status, read clears

// --------------------
// reset values
`define GPIO_LITE_RST_DIR  {`GPIO_LITE_WIDTH{1'b0}}  // all outputs
`define GPIO_LITE_RST_OE   {`GPIO_LITE_WIDTH{1'b0}}  // all pins tristated
`define GPIO_LITE_RST_OUT  {`GPIO_LITE_WIDTH{1'b0}}  // drive low once enabled

`endif

// File: hdl/gpio_lite_in_sync.sv
/* gpio_lite pin input path
   two-flop synchronizer, input value register, rising edge detect */

`timescale 1ns/10ps

module gpio_lite_in_sync
  import gpio_lite_pkg::*;
(
  input  logic       pclk13,        // apb clock
  input  logic       n_reset13,     // async reset, active low
  input  gpio_word_t pin_in,        // raw pins, asynchronous to pclk13
  output gpio_word_t pin_val,       // input value register
  output gpio_word_t pin_rise       // one cycle per rising edge
);

  // --------------------
  // synchronizer stages
  gpio_word_t sync_one;             // first stage, may go metastable
  gpio_word_t sync_two;             // second stage, settled

  always_ff @(posedge pclk13 or negedge n_reset13)
  begin : p_sync
    if (!n_reset13)
    begin
      sync_one <= '0;
      sync_two <= '0;
    end
    else
    begin
      sync_one <= pin_in;           // catch the pin
      sync_two <= sync_one;         // let it settle
    end
  end : p_sync

  // --------------------
  // input value register

  // one more stage, this is what IN reads back and the
  // reference for edge detection
  always_ff @(posedge pclk13 or negedge n_reset13)
  begin : p_in_val
    if (!n_reset13)
    begin
      pin_val <= '0;
    end
    else
    begin
      pin_val <= sync_two;
    end
  end : p_in_val

  // --------------------
  // rising edge

  // new sample high, registered value still low
  assign pin_rise = sync_two & ~pin_val;

endmodule : gpio_lite_in_sync

// File: hdl/gpio_lite_pkg.sv
/* gpio_lite shared types
   per-pin word and register address */

`include "gpio_lite_cfg.svh"

package gpio_lite_pkg;

  // --------------------
  // word types

  // one bit per pin, used for data, pins and registers
  typedef logic [`GPIO_LITE_WIDTH-1:0] gpio_word_t;

  // register offset on the apb port
  typedef logic [`GPIO_LITE_ADDR_W-1:0] gpio_addr_t;

endpackage : gpio_lite_pkg

// File: hdl/gpio_lite_regs.sv
/* gpio_lite register block
   apb decode, dir/oe/out registers, read mux, int status, pin drive */

`timescale 1ns/10ps
`include "gpio_lite_cfg.svh"

module gpio_lite_regs
  import gpio_lite_pkg::*;
(
  input  logic       pclk13,            // apb clock
  input  logic       n_reset13,         // async reset, active low
  input  logic       psel,              // apb select
  input  logic       penable,           // apb access phase
  input  logic       pwrite,            // 1 = write
  input  gpio_addr_t paddr,             // register offset
  input  gpio_word_t pwdata,            // write data
  input  gpio_word_t pin_val,           // synchronized pins
  input  gpio_word_t pin_rise,          // rising edge per pin
  input  gpio_word_t tri_state_enable,  // test, forces pins to Z
  output gpio_word_t prdata,            // read data, access phase only
  output gpio_word_t pin_out,           // value to pins
  output gpio_word_t pin_oe_n,          // output enable to pins, low active
  output logic       irq                // any status bit set
);

  // --------------------
  // apb strobes
  logic rd_strobe;                      // setup phase of a read
  logic wr_strobe;                      // access phase of a write

  // read data is registered at end of setup so it is ready
  // during the access phase with no wait state
  assign rd_strobe = psel & ~penable & ~pwrite;
  assign wr_strobe = psel & penable & pwrite;

  // --------------------
  // address decode
  logic ad_dir;
  logic ad_oe;
  logic ad_out;
  logic ad_int;

  assign ad_dir = (paddr == `GPIO_LITE_REG_DIR);
  assign ad_oe  = (paddr == `GPIO_LITE_REG_OE);
  assign ad_out = (paddr == `GPIO_LITE_REG_OUT);
  assign ad_int = (paddr == `GPIO_LITE_REG_INT);

  // --------------------
  // writable registers
  gpio_word_t dir_mode;                 // 1 = input, 0 = output
  gpio_word_t out_en;                   // 1 = drive the pin
  gpio_word_t out_val;                  // value driven

  always_ff @(posedge pclk13 or negedge n_reset13)
  begin : p_write
    if (!n_reset13)
    begin
      dir_mode <= `GPIO_LITE_RST_DIR;
      out_en   <= `GPIO_LITE_RST_OE;
      out_val  <= `GPIO_LITE_RST_OUT;
    end
    else if (wr_strobe)
    begin
      if (ad_dir)
      begin
        dir_mode <= pwdata;
      end
      if (ad_oe)
      begin
        out_en <= pwdata;
      end
      if (ad_out)
      begin
        out_val <= pwdata;
      end
    end
  end : p_write

  // --------------------
  // interrupt status
  gpio_word_t int_status;
  gpio_word_t int_set;                  // edges on input pins
  gpio_word_t int_clr;                  // read of INT clears all bits

  assign int_set = pin_rise & dir_mode; // output-mode pins never flag
  assign int_clr = {`GPIO_LITE_WIDTH{rd_strobe & ad_int}};

  // set wins over a clear in the same cycle, so an edge landing
  // on the read is kept for the next one
  always_ff @(posedge pclk13 or negedge n_reset13)
  begin : p_int
    if (!n_reset13)
    begin
      int_status <= '0;
    end
    else
    begin
      int_status <= (int_status & ~int_clr) | int_set;
    end
  end : p_int

  assign irq = |int_status;             // level, no extra flop

  // --------------------
  // read path
  gpio_word_t rd_mux;

  always_comb
  begin : p_rd_mux
    case (paddr)
      `GPIO_LITE_REG_DIR: rd_mux = dir_mode;
      `GPIO_LITE_REG_OE:  rd_mux = out_en;
      `GPIO_LITE_REG_OUT: rd_mux = out_val;
      `GPIO_LITE_REG_INT: rd_mux = int_status;  // value before the clear
      `GPIO_LITE_REG_IN:  rd_mux = pin_val;
      default:            rd_mux = pin_val;     // unmapped reads the pins
    endcase
  end : p_rd_mux

  always_ff @(posedge pclk13 or negedge n_reset13)
  begin : p_rdata
    if (!n_reset13)
    begin
      prdata <= '0;
    end
    else if (rd_strobe)
    begin
      prdata <= rd_mux;
    end
    else
    begin
      prdata <= '0;                     // zero outside a read access
    end
  end : p_rdata

  // --------------------
  // pin drive
  assign pin_out = out_val;

  // low only for an enabled output pin not held off by test
  assign pin_oe_n = ~(out_en & ~dir_mode) | tri_state_enable;

endmodule : gpio_lite_regs

// File: verif/gpio_lite_checker.sv
/* gpio_lite port checker
   read data idle, tristate override and irq clear assertions, bound to the top */

`timescale 1ns/10ps
`include "gpio_lite_cfg.svh"

module gpio_lite_checker
  import gpio_lite_pkg::*;
(
  input logic       pclk13,
  input logic       n_reset13,
  input logic       psel,
  input logic       penable,
  input logic       pwrite,
  input gpio_addr_t paddr,
  input gpio_word_t prdata,
  input gpio_word_t pin_in,
  input gpio_word_t tri_state_enable,
  input gpio_word_t pin_oe_n,
  input logic       irq
);

  // --------------------
  // helper terms
  logic       rd_setup;                 // setup phase of any read
  logic       rd_int_setup;             // setup phase of an INT read
  logic       rise_now;                 // some pin went 0 to 1 this cycle
  gpio_word_t pin_in_d;                 // pins one cycle back
  logic [3:0] rise_hist;                // rise flags, older cycles

  assign rd_setup     = psel & ~penable & ~pwrite;
  assign rd_int_setup = rd_setup & (paddr == `GPIO_LITE_REG_INT);
  assign rise_now     = |(pin_in & ~pin_in_d);

  always_ff @(posedge pclk13 or negedge n_reset13)
  begin : p_hist
    if (!n_reset13)
    begin
      pin_in_d  <= '0;
      rise_hist <= '0;
    end
    else
    begin
      pin_in_d  <= pin_in;
      rise_hist <= {rise_hist[2:0], rise_now};  // shift in newest
    end
  end : p_hist

  // --------------------
  // assertions

  // data only in the access phase of a read
  a_prdata_idle : assert property (@(posedge pclk13) disable iff (!n_reset13)
    !rd_setup |=> (prdata == '0))
    else $error("prdata not zero outside a read access phase");

  // test override always wins over the enable
  a_tri_state : assert property (@(posedge pclk13) disable iff (!n_reset13)
    ((pin_oe_n & tri_state_enable) == tri_state_enable))
    else $error("pin_oe_n low on a pin held by tri_state_enable");

  // a read of INT clears everything unless an edge is still in flight
  a_irq_clear : assert property (@(posedge pclk13) disable iff (!n_reset13)
    (rd_int_setup && !rise_now && (rise_hist == '0)) |=> !irq)
    else $error("irq still high after a read of INT with quiet pins");

endmodule : gpio_lite_checker

bind gpio_lite gpio_lite_checker u_checker (
  .pclk13           (pclk13),
  .n_reset13        (n_reset13),
  .psel             (psel),
  .penable          (penable),
  .pwrite           (pwrite),
  .paddr            (paddr),
  .prdata           (prdata),
  .pin_in           (pin_in),
  .tri_state_enable (tri_state_enable),
  .pin_oe_n         (pin_oe_n),
  .irq              (irq)
);

// File: verif/gpio_lite_tb.sv
/* gpio_lite testbench
   clock, reset, lfsr, apb tasks, compare tasks, directed tests, watchdog */

`timescale 1ns/10ps
`include "gpio_lite_cfg.svh"

module gpio_lite_tb
  import gpio_lite_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 2000;  // sequence is under 200 cycles
  localparam logic [31:0] LFSR_SEED = 32'h69cd_ca19;
  localparam gpio_addr_t ADDR_UNMAPPED = 6'h3C;

  // --------------------
  // dut signals
  logic       pclk13;
  logic       n_reset13;
  logic       psel;
  logic       penable;
  logic       pwrite;
  gpio_addr_t paddr;
  gpio_word_t pwdata;
  gpio_word_t prdata;
  gpio_word_t pin_in;
  gpio_word_t tri_state_enable;
  gpio_word_t pin_out;
  gpio_word_t pin_oe_n;
  logic       irq;

  int         err_count;
  int         check_count;
  int         test_count;
  int         cycle_count;
  logic [31:0] lfsr_state;

  gpio_lite UUT (
    .pclk13           (pclk13),
    .n_reset13        (n_reset13),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .paddr            (paddr),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pin_in           (pin_in),
    .tri_state_enable (tri_state_enable),
    .pin_out          (pin_out),
    .pin_oe_n         (pin_oe_n),
    .irq              (irq)
  );

  // --------------------
  // clock and watchdog
  initial pclk13 = 1'b0;
  always #4 pclk13 = ~pclk13;           // 8 ns period

  initial
  begin : p_watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge pclk13);
      cycle_count++;                    // one per clock
    end
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // --------------------
  // random words, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic gpio_word_t random_word();
    gpio_word_t w;
    for (int i = 0; i < `GPIO_LITE_WIDTH; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      w[i] = lfsr_state[0];
    end
    return w;
  endfunction

  // --------------------
  // bus and timing helpers
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge pclk13);
    #1;
  endtask

  task automatic apb_write(input gpio_addr_t addr, input gpio_word_t data);
    @(posedge pclk13);
    #1;
    psel    = 1'b1;                     // setup
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge pclk13);
    #1;
    penable = 1'b1;                     // access, lands at next edge
    @(posedge pclk13);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input gpio_addr_t addr, output gpio_word_t data);
    @(posedge pclk13);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge pclk13);
    #1;
    penable = 1'b1;
    data    = prdata;                   // held for the whole access phase
    @(posedge pclk13);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // wait for the level interrupt, bounded
  task automatic wait_irq(input string test, input int limit);
    int n;
    n = 0;
    while (irq !== 1'b1 && n < limit)
    begin
      idle_cycles(1);
      n++;
    end
    if (irq !== 1'b1)
    begin
      $display("%s: irq did not go high within %0d cycles", test, limit);
      err_count++;
    end
  endtask

  // --------------------
  // compare tasks
  task automatic check_word(input string test, input string what,
                            input gpio_word_t expected, input gpio_word_t actual);
    check_count++;
    if (actual !== expected)
    begin
      $display("mismatch %s (%s): expected %h actual %h", test, what, expected, actual);
      err_count++;
    end
  endtask

  task automatic check_bit(input string test, input string what,
                           input logic expected, input logic actual);
    check_count++;
    if (actual !== expected)
    begin
      $display("mismatch %s (%s): expected %b actual %b", test, what, expected, actual);
      err_count++;
    end
  endtask

  task automatic finish_test(input string test, input int errs_at_start);
    test_count++;
    if (err_count == errs_at_start)
    begin
      $display("test %s done, ok", test);
    end
    else
    begin
      $display("test %s done, %0d errors", test, err_count - errs_at_start);
    end
  endtask

  // --------------------
  // directed tests
  task automatic test_reset();
    gpio_word_t rd;
    int errs;
    errs = err_count;
    apb_read(`GPIO_LITE_REG_DIR, rd);
    check_word("reset", "DIR", '0, rd);
    apb_read(`GPIO_LITE_REG_OE, rd);
    check_word("reset", "OE", '0, rd);
    apb_read(`GPIO_LITE_REG_OUT, rd);
    check_word("reset", "OUT", '0, rd);
    apb_read(`GPIO_LITE_REG_IN, rd);
    check_word("reset", "IN", '0, rd);
    apb_read(`GPIO_LITE_REG_INT, rd);
    check_word("reset", "INT", '0, rd);
    check_word("reset", "pin_oe_n", '1, pin_oe_n);  // nothing enabled
    check_word("reset", "pin_out", '0, pin_out);
    check_bit("reset", "irq", 1'b0, irq);
    finish_test("reset", errs);
  endtask

  task automatic test_readback();
    gpio_word_t w_dir;
    gpio_word_t w_oe;
    gpio_word_t w_out;
    gpio_word_t rd;
    int errs;
    errs = err_count;
    for (int r = 0; r < 3; r++)
    begin
      w_dir = random_word();
      w_oe  = random_word();
      w_out = random_word();
      apb_write(`GPIO_LITE_REG_DIR, w_dir);
      apb_write(`GPIO_LITE_REG_OE, w_oe);
      apb_write(`GPIO_LITE_REG_OUT, w_out);
      apb_read(`GPIO_LITE_REG_DIR, rd);
      check_word("readback", "DIR", w_dir, rd);
      apb_read(`GPIO_LITE_REG_OE, rd);
      check_word("readback", "OE", w_oe, rd);
      apb_read(`GPIO_LITE_REG_OUT, rd);
      check_word("readback", "OUT", w_out, rd);
      check_word("readback", "pin_out", w_out, pin_out);  // straight from OUT
    end
    finish_test("readback", errs);
  endtask

  task automatic test_oe_rule();
    gpio_word_t w_dir;
    gpio_word_t w_oe;
    gpio_word_t w_tse;
    gpio_word_t expected;
    int errs;
    errs = err_count;
    for (int r = 0; r < 4; r++)
    begin
      w_dir = random_word();
      w_oe  = random_word();
      w_tse = random_word();
      apb_write(`GPIO_LITE_REG_DIR, w_dir);
      apb_write(`GPIO_LITE_REG_OE, w_oe);
      tri_state_enable = w_tse;
      idle_cycles(1);
      // pin by pin, driven only if enabled, output and not forced off
      for (int i = 0; i < `GPIO_LITE_WIDTH; i++)
      begin
        if (w_oe[i] && !w_dir[i] && !w_tse[i])
        begin
          expected[i] = 1'b0;
        end
        else
        begin
          expected[i] = 1'b1;
        end
      end
      check_word("oe_rule", "pin_oe_n", expected, pin_oe_n);
    end
    tri_state_enable = '0;
    finish_test("oe_rule", errs);
  endtask

  task automatic test_input();
    gpio_word_t w_pins;
    gpio_word_t rd;
    int errs;
    errs = err_count;
    w_pins = random_word();
    pin_in = w_pins;
    idle_cycles(4);                     // through both sync flops and IN
    apb_read(`GPIO_LITE_REG_IN, rd);
    check_word("input", "IN", w_pins, rd);
    apb_read(ADDR_UNMAPPED, rd);
    check_word("input", "unmapped", w_pins, rd);
    finish_test("input", errs);
  endtask

  task automatic test_interrupts();
    gpio_word_t w_dir;
    gpio_word_t w_rise;
    gpio_word_t rd;
    int errs;
    errs = err_count;
    w_dir = random_word();
    w_dir[0] = 1'b1;                    // at least one input pin
    w_dir[`GPIO_LITE_WIDTH-1] = 1'b0;   // and one output pin
    apb_write(`GPIO_LITE_REG_DIR, w_dir);
    pin_in = '0;
    idle_cycles(5);                     // falls settle, must set nothing
    apb_read(`GPIO_LITE_REG_INT, rd);   // clear leftovers
    apb_read(`GPIO_LITE_REG_INT, rd);
    check_word("interrupts", "INT after clear", '0, rd);
    check_bit("interrupts", "irq after clear", 1'b0, irq);

    w_rise = random_word();
    w_rise[0] = 1'b1;
    w_rise[`GPIO_LITE_WIDTH-1] = 1'b1;  // output-mode pin rises too
    pin_in = w_rise;
    wait_irq("interrupts", 10);
    apb_read(`GPIO_LITE_REG_INT, rd);
    check_word("interrupts", "INT rising inputs", w_rise & w_dir, rd);
    check_bit("interrupts", "irq after INT read", 1'b0, irq);

    pin_in = '0;                        // falling edges only
    idle_cycles(5);
    check_bit("interrupts", "irq after falls", 1'b0, irq);
    apb_read(`GPIO_LITE_REG_INT, rd);
    check_word("interrupts", "INT second read", '0, rd);
    check_bit("interrupts", "irq at end", 1'b0, irq);
    finish_test("interrupts", errs);
  endtask

  // --------------------
  // main sequence
  initial
  begin : p_main
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    paddr            = '0;
    pwdata           = '0;
    pin_in           = '0;
    tri_state_enable = '0;
    n_reset13        = 1'b0;
    err_count        = 0;
    check_count      = 0;
    test_count       = 0;
    lfsr_state       = LFSR_SEED;

    repeat (10) @(posedge pclk13);      // reset for 10 cycles
    #1;
    n_reset13 = 1'b1;

    test_reset();
    test_readback();
    test_oe_rule();
    test_input();
    test_interrupts();

    $display("summary: %0d tests, %0d checks, %0d errors",
             test_count, check_count, err_count);
    if (err_count == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end : p_main

endmodule : gpio_lite_tb
